// File: rtl/rv32i_types.sv
/*
    ISA-level encodings for the RV32I decode/execute core.
    Opcodes, funct3 groups, ALU operations and the datapath mux selects.
    Imported by the packet package and by every stage that decodes them.
*/
package rv32i_types;

localparam int XLEN = 32;
localparam int NUM_REGS = 32;

typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
} rv32i_opcode;

typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
} branch_funct3_t;

typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
} load_funct3_t;

typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
} store_funct3_t;

typedef enum logic [2:0] {
    add  = 3'b000,
    sll  = 3'b001,
    slt  = 3'b010,
    sltu = 3'b011,
    axor = 3'b100,
    sr   = 3'b101,
    aor  = 3'b110,
    aand = 3'b111
} arith_funct3_t;

typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
} alu_ops;

typedef enum logic {
    alu1_rs1 = 1'b0,
    alu1_pc  = 1'b1
} alumux1_sel_t;

typedef enum logic [2:0] {
    alu2_i_imm = 3'b000,
    alu2_u_imm = 3'b001,
    alu2_b_imm = 3'b010,
    alu2_s_imm = 3'b011,
    alu2_j_imm = 3'b100,
    alu2_rs2   = 3'b101
} alumux2_sel_t;

typedef enum logic {
    cmp_rs2   = 1'b0,
    cmp_i_imm = 1'b1
} cmpmux_sel_t;

typedef enum logic [3:0] {
    rf_alu_out  = 4'd0,
    rf_br_en    = 4'd1,
    rf_u_imm    = 4'd2,
    rf_lw       = 4'd3,
    rf_pc_plus4 = 4'd4,
    rf_lb       = 4'd5,
    rf_lbu      = 4'd6,
    rf_lh       = 4'd7,
    rf_lhu      = 4'd8
} regfilemux_sel_t;

endpackage : rv32i_types

// File: rtl/rv32i_packet.sv
/*
    Structures passed between the pipeline stages of the RV32I core.
    The instruction union gives the R, I, S, B, U and J views of one word;
    the packets are the stage registers and the core's output bundles.
*/
package rv32i_packet;

import rv32i_types::*;

typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    rv32i_opcode opcode;
} r_format_t;

typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    rv32i_opcode opcode;
} i_format_t;

typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    rv32i_opcode opcode;
} s_format_t;

typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4_1;
    logic        imm11;
    rv32i_opcode opcode;
} b_format_t;

typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    rv32i_opcode opcode;
} u_format_t;

typedef struct packed {
    logic        imm20;
    logic [9:0]  imm10_1;
    logic        imm11;
    logic [7:0]  imm19_12;
    logic [4:0]  rd;
    rv32i_opcode opcode;
} j_format_t;

typedef union packed {
    r_format_t r;
    i_format_t i;
    s_format_t s;
    b_format_t b;
    u_format_t u;
    j_format_t j;
} rv32i_inst_u;

// grouped by the stage that consumes each field
typedef struct packed {
    logic            ex;
    alu_ops          aluop;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    branch_funct3_t  cmpop;
    cmpmux_sel_t     cmpmux_sel;
    logic            mem;
    logic            data_mem_read;
    logic            data_mem_write;
    logic            wb;
    regfilemux_sel_t regfilemux_sel;
    logic            load_regfile;
} rv32i_ctrl_packet_t;

typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    pc;
    rv32i_ctrl_packet_t ctrl;
    logic [XLEN-1:0]    rs1_val;
    logic [XLEN-1:0]    rs2_val;
    logic [XLEN-1:0]    i_imm;
    logic [XLEN-1:0]    s_imm;
    logic [XLEN-1:0]    b_imm;
    logic [XLEN-1:0]    u_imm;
    logic [XLEN-1:0]    j_imm;
    logic [4:0]         rd;
    logic [2:0]         funct3;
} dx_packet_t;

typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    pc;
    rv32i_ctrl_packet_t ctrl;
    logic [XLEN-1:0]    alu_out;
    logic               br_en;
    logic [XLEN-1:0]    u_imm;
    logic [4:0]         rd;
    logic [2:0]         funct3;
} xw_packet_t;

typedef struct packed {
    logic            read;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
} mem_req_t;

typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
} branch_t;

typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
} wb_t;

endpackage : rv32i_packet

// File: rtl/control_rom.sv
/*
    Control decoder for the decode stage.
    Maps opcode, funct3 and funct7 to the control packet that steers
    execute, the memory request and writeback. Purely combinational.
*/
`timescale 1ns/1ns

module control_rom (
    input  rv32i_types::rv32i_opcode         i_opcode,
    input  logic [2:0]                       i_funct3,
    input  logic [6:0]                       i_funct7,
    output rv32i_packet::rv32i_ctrl_packet_t o_ctrl
);
    import rv32i_types::*;

    alumux2_sel_t arith_src;
    cmpmux_sel_t  arith_cmp;

    // op_imm takes its second operand from the immediate
    assign arith_src = (i_opcode == op_reg) ? alu2_rs2 : alu2_i_imm;
    assign arith_cmp = (i_opcode == op_reg) ? cmp_rs2 : cmp_i_imm;

    function automatic void set_alu(alumux1_sel_t sel1, alumux2_sel_t sel2, alu_ops op);
        o_ctrl.alumux1_sel = sel1;
        o_ctrl.alumux2_sel = sel2;
        o_ctrl.aluop = op;
    endfunction

    function automatic void set_cmp(cmpmux_sel_t sel, branch_funct3_t op);
        o_ctrl.cmpmux_sel = sel;
        o_ctrl.cmpop = op;
    endfunction

    function automatic void load_rf(regfilemux_sel_t sel);
        o_ctrl.wb = 1'b1;
        o_ctrl.load_regfile = 1'b1;
        o_ctrl.regfilemux_sel = sel;
    endfunction

    always_comb begin
        o_ctrl.ex = 1'b0;
        o_ctrl.aluop = alu_add;
        o_ctrl.alumux1_sel = alu1_rs1;
        o_ctrl.alumux2_sel = alu2_i_imm;
        o_ctrl.cmpop = beq;
        o_ctrl.cmpmux_sel = cmp_rs2;
        o_ctrl.mem = 1'b0;
        o_ctrl.data_mem_read = 1'b0;
        o_ctrl.data_mem_write = 1'b0;
        o_ctrl.wb = 1'b0;
        o_ctrl.regfilemux_sel = rf_alu_out;
        o_ctrl.load_regfile = 1'b0;

        case (i_opcode)
            op_lui: begin
                load_rf(rf_u_imm);
            end
            op_auipc: begin
                o_ctrl.ex = 1'b1;
                set_alu(alu1_pc, alu2_u_imm, alu_add);
                load_rf(rf_alu_out);
            end
            op_jal: begin
                o_ctrl.ex = 1'b1;
                set_alu(alu1_pc, alu2_j_imm, alu_add);
                load_rf(rf_pc_plus4);
            end
            op_jalr: begin
                o_ctrl.ex = 1'b1;
                set_alu(alu1_rs1, alu2_i_imm, alu_add);
                load_rf(rf_pc_plus4);
            end
            op_br: begin
                // alu forms the target, comparator the condition
                o_ctrl.ex = 1'b1;
                set_alu(alu1_pc, alu2_b_imm, alu_add);
                set_cmp(cmp_rs2, branch_funct3_t'(i_funct3));
            end
            op_load: begin
                o_ctrl.ex = 1'b1;
                o_ctrl.mem = 1'b1;
                o_ctrl.data_mem_read = 1'b1;
                case (load_funct3_t'(i_funct3))
                    lb:      load_rf(rf_lb);
                    lh:      load_rf(rf_lh);
                    lw:      load_rf(rf_lw);
                    lbu:     load_rf(rf_lbu);
                    lhu:     load_rf(rf_lhu);
                    default: ;
                endcase
            end
            op_store: begin
                o_ctrl.ex = 1'b1;
                set_alu(alu1_rs1, alu2_s_imm, alu_add);
                o_ctrl.mem = 1'b1;
                o_ctrl.data_mem_write = 1'b1;
            end
            op_imm, op_reg: begin
                o_ctrl.ex = 1'b1;
                load_rf(rf_alu_out);
                case (arith_funct3_t'(i_funct3))
                    add: begin
                        // funct7[5] means sub only for register operands
                        set_alu(alu1_rs1, arith_src,
                                (i_opcode == op_reg && i_funct7[5]) ? alu_sub : alu_add);
                    end
                    sll:  set_alu(alu1_rs1, arith_src, alu_sll);
                    slt: begin
                        set_cmp(arith_cmp, blt);
                        load_rf(rf_br_en);
                    end
                    sltu: begin
                        set_cmp(arith_cmp, bltu);
                        load_rf(rf_br_en);
                    end
                    axor: set_alu(alu1_rs1, arith_src, alu_xor);
                    sr:   set_alu(alu1_rs1, arith_src, i_funct7[5] ? alu_sra : alu_srl);
                    aor:  set_alu(alu1_rs1, arith_src, alu_or);
                    aand: set_alu(alu1_rs1, arith_src, alu_and);
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule : control_rom

// File: rtl/regfile.sv
/*
    Integer register file, two read ports and one write port.
    x0 reads as zero; a read of the register being written this cycle
    returns the incoming data.
*/
`timescale 1ns/1ns

module regfile (
    input  logic                           clk,
    input  logic                           i_reset,
    input  rv32i_packet::wb_t              i_wb,
    input  logic [4:0]                     i_rs1,
    input  logic [4:0]                     i_rs2,
    output logic [rv32i_types::XLEN-1:0]   o_rs1_val,
    output logic [rv32i_types::XLEN-1:0]   o_rs2_val
);
    import rv32i_types::*;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    function automatic logic [XLEN-1:0] read_port(logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        if (i_wb.valid && i_wb.rd == addr)
            return i_wb.data;
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1);
        o_rs2_val = read_port(i_rs2);
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int r = 1; r < NUM_REGS; r++)
                regs[r] <= '0;
        end else if (i_wb.valid && i_wb.rd != 5'd0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

endmodule : regfile

// File: rtl/alu.sv
/*
    32-bit integer ALU for the execute stage.
    Shifts take their amount from the low 5 bits of the second operand.
*/
`timescale 1ns/1ns

module alu (
    input  rv32i_types::alu_ops          i_aluop,
    input  logic [rv32i_types::XLEN-1:0] i_a,
    input  logic [rv32i_types::XLEN-1:0] i_b,
    output logic [rv32i_types::XLEN-1:0] o_f
);
    import rv32i_types::*;

    always_comb begin
        case (i_aluop)
            alu_add: o_f = i_a + i_b;
            alu_sll: o_f = i_a << i_b[4:0];
            alu_sra: o_f = $unsigned($signed(i_a) >>> i_b[4:0]);
            alu_sub: o_f = i_a - i_b;
            alu_xor: o_f = i_a ^ i_b;
            alu_srl: o_f = i_a >> i_b[4:0];
            alu_or:  o_f = i_a | i_b;
            alu_and: o_f = i_a & i_b;
            default: o_f = i_a + i_b;
        endcase
    end

endmodule : alu

// File: rtl/decode_stage.sv
/*
    Decode stage. Looks up control, builds the five immediates from the
    instruction views and registers them with the operands read from the
    register file. An invalid slot registers a bubble.
*/
`timescale 1ns/1ns

module decode_stage (
    input  logic                         clk,
    input  logic                         i_reset,
    input  rv32i_packet::rv32i_inst_u    i_inst,
    input  logic [rv32i_types::XLEN-1:0] i_pc,
    input  logic                         i_inst_valid,
    input  logic [rv32i_types::XLEN-1:0] i_rs1_val,
    input  logic [rv32i_types::XLEN-1:0] i_rs2_val,
    output rv32i_packet::dx_packet_t     o_dx
);
    import rv32i_types::*;
    import rv32i_packet::*;

    rv32i_ctrl_packet_t ctrl;
    dx_packet_t         dx_next;

    control_rom control_rom_i (
        .i_opcode (i_inst.r.opcode),
        .i_funct3 (i_inst.r.funct3),
        .i_funct7 (i_inst.r.funct7),
        .o_ctrl   (ctrl)
    );

    always_comb begin
        dx_next = '0;
        if (i_inst_valid) begin
            dx_next.valid = 1'b1;
            dx_next.pc = i_pc;
            dx_next.ctrl = ctrl;
            dx_next.rs1_val = i_rs1_val;
            dx_next.rs2_val = i_rs2_val;
            dx_next.i_imm = {{(XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
            dx_next.s_imm = {{(XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
            dx_next.b_imm = {{(XLEN-12){i_inst.b.imm12}}, i_inst.b.imm11,
                             i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
            dx_next.u_imm = {i_inst.u.imm, 12'h000};
            dx_next.j_imm = {{(XLEN-20){i_inst.j.imm20}}, i_inst.j.imm19_12,
                             i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};
            dx_next.rd = i_inst.r.rd;
            dx_next.funct3 = i_inst.r.funct3;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset)
            o_dx <= '0;
        else
            o_dx <= dx_next;
    end

endmodule : decode_stage

// File: rtl/execute_stage.sv
/*
    Execute stage. Picks the ALU and comparator operands, reports the
    branch or jump outcome and the data-memory request from the registered
    decode packet, then registers the result for writeback.
*/
`timescale 1ns/1ns

module execute_stage (
    input  logic                     clk,
    input  logic                     i_reset,
    input  rv32i_packet::dx_packet_t i_dx,
    output rv32i_packet::xw_packet_t o_xw,
    output rv32i_packet::mem_req_t   o_mem_req,
    output rv32i_packet::branch_t    o_branch
);
    import rv32i_types::*;
    import rv32i_packet::*;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] cmp_b;
    logic            br_en;
    logic            is_jump;
    logic            is_jalr;
    logic            is_branch;
    xw_packet_t      xw_next;

    assign alu_a = (i_dx.ctrl.alumux1_sel == alu1_pc) ? i_dx.pc : i_dx.rs1_val;
    assign cmp_b = (i_dx.ctrl.cmpmux_sel == cmp_i_imm) ? i_dx.i_imm : i_dx.rs2_val;

    always_comb begin
        case (i_dx.ctrl.alumux2_sel)
            alu2_u_imm: alu_b = i_dx.u_imm;
            alu2_b_imm: alu_b = i_dx.b_imm;
            alu2_s_imm: alu_b = i_dx.s_imm;
            alu2_j_imm: alu_b = i_dx.j_imm;
            alu2_rs2:   alu_b = i_dx.rs2_val;
            default:    alu_b = i_dx.i_imm;
        endcase
    end

    alu alu_i (
        .i_aluop (i_dx.ctrl.aluop),
        .i_a     (alu_a),
        .i_b     (alu_b),
        .o_f     (alu_out)
    );

    // comparator always uses rs1 as its first operand
    always_comb begin
        case (i_dx.ctrl.cmpop)
            beq:     br_en = (i_dx.rs1_val == cmp_b);
            bne:     br_en = (i_dx.rs1_val != cmp_b);
            blt:     br_en = ($signed(i_dx.rs1_val) < $signed(cmp_b));
            bge:     br_en = ($signed(i_dx.rs1_val) >= $signed(cmp_b));
            bltu:    br_en = (i_dx.rs1_val < cmp_b);
            bgeu:    br_en = (i_dx.rs1_val >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

    // jumps are the only ops that write pc+4; branches only use execute
    assign is_jump = i_dx.ctrl.load_regfile && i_dx.ctrl.regfilemux_sel == rf_pc_plus4;
    assign is_jalr = is_jump && i_dx.ctrl.alumux1_sel == alu1_rs1;
    assign is_branch = i_dx.ctrl.ex && !i_dx.ctrl.mem && !i_dx.ctrl.wb;

    assign o_branch.taken = i_dx.valid && (is_jump || (is_branch && br_en));
    assign o_branch.target = {alu_out[XLEN-1:1], alu_out[0] & ~is_jalr};

    assign o_mem_req.read = i_dx.valid && i_dx.ctrl.mem && i_dx.ctrl.data_mem_read;
    assign o_mem_req.write = i_dx.valid && i_dx.ctrl.mem && i_dx.ctrl.data_mem_write;
    assign o_mem_req.addr = alu_out;
    assign o_mem_req.wdata = i_dx.rs2_val;

    always_comb begin
        xw_next.valid = i_dx.valid;
        xw_next.pc = i_dx.pc;
        xw_next.ctrl = i_dx.ctrl;
        xw_next.alu_out = alu_out;
        xw_next.br_en = br_en;
        xw_next.u_imm = i_dx.u_imm;
        xw_next.rd = i_dx.rd;
        xw_next.funct3 = i_dx.funct3;
    end

    always_ff @(posedge clk) begin
        if (i_reset)
            o_xw <= '0;
        else
            o_xw <= xw_next;
    end

endmodule : execute_stage

// File: rtl/writeback_stage.sv
/*
    Writeback stage. Extracts and extends load data at the request offset
    and selects the value written to rd. The write itself happens in the
    register file on the next edge.
*/
`timescale 1ns/1ns

module writeback_stage (
    input  rv32i_packet::xw_packet_t     i_xw,
    input  logic [rv32i_types::XLEN-1:0] i_mem_rdata,
    output rv32i_packet::wb_t            o_wb
);
    import rv32i_types::*;

    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_data;

    // address low bits come from the alu result of the load
    assign ld_byte = i_mem_rdata[{i_xw.alu_out[1:0], 3'b000} +: 8];
    assign ld_half = i_xw.alu_out[1] ? i_mem_rdata[31:16] : i_mem_rdata[15:0];

    always_comb begin
        case (load_funct3_t'(i_xw.funct3))
            lb:      ld_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            lh:      ld_data = {{(XLEN-16){ld_half[15]}}, ld_half};
            lbu:     ld_data = {{(XLEN-8){1'b0}}, ld_byte};
            lhu:     ld_data = {{(XLEN-16){1'b0}}, ld_half};
            default: ld_data = i_mem_rdata;
        endcase
    end

    always_comb begin
        case (i_xw.ctrl.regfilemux_sel)
            rf_br_en:    o_wb.data = {{(XLEN-1){1'b0}}, i_xw.br_en};
            rf_u_imm:    o_wb.data = i_xw.u_imm;
            rf_pc_plus4: o_wb.data = i_xw.pc + 32'd4;
            rf_lb, rf_lh, rf_lw, rf_lbu, rf_lhu: o_wb.data = ld_data;
            default:     o_wb.data = i_xw.alu_out;
        endcase
    end

    assign o_wb.valid = i_xw.valid && i_xw.ctrl.wb && i_xw.ctrl.load_regfile;
    assign o_wb.rd = i_xw.rd;

endmodule : writeback_stage

// File: rtl/rv32i_dx_core.sv
/*
    Decode, execute and writeback pipeline of an RV32I integer core.
    One instruction and pc are sampled per cycle on i_inst_valid; the memory
    request and branch outcome follow one cycle later, the write to rd two.
*/
`timescale 1ns/1ns

module rv32i_dx_core (
    input  logic                         clk,
    input  logic                         i_reset,
    input  rv32i_packet::rv32i_inst_u    i_inst,
    input  logic [rv32i_types::XLEN-1:0] i_pc,
    input  logic                         i_inst_valid,
    input  logic [rv32i_types::XLEN-1:0] i_mem_rdata,
    output rv32i_packet::mem_req_t       o_mem_req,
    output rv32i_packet::branch_t        o_branch,
    output rv32i_packet::wb_t            o_wb
);
    import rv32i_types::*;
    import rv32i_packet::*;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    dx_packet_t      dx;
    xw_packet_t      xw;

    // operands are read in the same cycle the instruction is presented
    regfile regfile_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_wb      (o_wb),
        .i_rs1     (i_inst.r.rs1),
        .i_rs2     (i_inst.r.rs2),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val)
    );

    decode_stage decode_stage_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_inst_valid (i_inst_valid),
        .i_rs1_val    (rs1_val),
        .i_rs2_val    (rs2_val),
        .o_dx         (dx)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_dx      (dx),
        .o_xw      (xw),
        .o_mem_req (o_mem_req),
        .o_branch  (o_branch)
    );

    writeback_stage writeback_stage_i (
        .i_xw        (xw),
        .i_mem_rdata (i_mem_rdata),
        .o_wb        (o_wb)
    );

endmodule : rv32i_dx_core

// File: bench/clock_gen.sv
/*
    Free-running testbench clock, 4 ns period.
    Starts low so the first rising edge is at 2 ns.
*/
`timescale 1ns/1ns

module clock_gen (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
    end

    always #2 o_clk = ~o_clk;

endmodule : clock_gen

// File: bench/tb_rv32i_dx.sv
/*
    Testbench for the RV32I decode/execute/writeback core.
    Reads instructions and expected results from the cases file, issues
    them with optional bubbles, plays the data memory for loads and checks
    the memory request, branch outcome and register write at fixed offsets.
*/
`timescale 1ns/1ns

module tb_rv32i_dx;
    import rv32i_types::*;
    import rv32i_packet::*;

    localparam int WORDS_PER_CASE = 12;
    localparam int MAX_CASES = 64;
    localparam int MAX_CYCLES = 2000;

    logic            clk;
    logic            i_reset;
    rv32i_inst_u     i_inst;
    logic [XLEN-1:0] i_pc;
    logic            i_inst_valid;
    logic [XLEN-1:0] i_mem_rdata;
    mem_req_t        o_mem_req;
    branch_t         o_branch;
    wb_t             o_wb;

    logic [31:0] case_words [0:WORDS_PER_CASE*MAX_CASES-1];
    int          slots[$];
    // case index issued at the last three edges, -1 for a bubble
    int          hist [0:2];
    int          num_cases;
    int          checked;
    int          seed;
    bit          checking;

    clock_gen clock_gen_i (
        .o_clk (clk)
    );

    rv32i_dx_core rv32i_dx_core_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_inst_valid (i_inst_valid),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_req    (o_mem_req),
        .o_branch     (o_branch),
        .o_wb         (o_wb)
    );

    function automatic logic [31:0] case_word(int k, int col);
        return case_words[k*WORDS_PER_CASE+col];
    endfunction

    function automatic mem_req_t exp_mem_req(int k);
        mem_req_t    e;
        logic [31:0] rw;
        e = '0;
        if (k >= 0) begin
            rw = case_word(k, 4);
            e.read = rw[1];
            e.write = rw[0];
            e.addr = case_word(k, 5);
            e.wdata = case_word(k, 6);
        end
        return e;
    endfunction

    function automatic branch_t exp_branch(int k);
        branch_t     e;
        logic [31:0] taken;
        e = '0;
        if (k >= 0) begin
            taken = case_word(k, 7);
            e.taken = taken[0];
            e.target = case_word(k, 8);
        end
        return e;
    endfunction

    function automatic wb_t exp_wb(int k);
        wb_t         e;
        logic [31:0] valid;
        logic [31:0] rd;
        e = '0;
        if (k >= 0) begin
            valid = case_word(k, 9);
            rd = case_word(k, 10);
            e.valid = valid[0];
            e.rd = rd[4:0];
            e.data = case_word(k, 11);
        end
        return e;
    endfunction

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
        stop_with_failure();
    endtask

    task automatic check_mem_req(mem_req_t got, mem_req_t exp);
        if (got.read !== exp.read)
            report_mismatch("o_mem_req.read", 32'(got.read), 32'(exp.read));
        if (got.write !== exp.write)
            report_mismatch("o_mem_req.write", 32'(got.write), 32'(exp.write));
        // address and data only mean something on an access
        if ((exp.read || exp.write) && got.addr !== exp.addr)
            report_mismatch("o_mem_req.addr", got.addr, exp.addr);
        if (exp.write && got.wdata !== exp.wdata)
            report_mismatch("o_mem_req.wdata", got.wdata, exp.wdata);
    endtask

    task automatic check_branch(branch_t got, branch_t exp);
        if (got.taken !== exp.taken)
            report_mismatch("o_branch.taken", 32'(got.taken), 32'(exp.taken));
        if (exp.taken && got.target !== exp.target)
            report_mismatch("o_branch.target", got.target, exp.target);
    endtask

    task automatic check_wb(wb_t got, wb_t exp);
        if (got.valid !== exp.valid)
            report_mismatch("o_wb.valid", 32'(got.valid), 32'(exp.valid));
        if (exp.valid && got.rd !== exp.rd)
            report_mismatch("o_wb.rd", 32'(got.rd), 32'(exp.rd));
        if (exp.valid && got.data !== exp.data)
            report_mismatch("o_wb.data", got.data, exp.data);
    endtask

    task automatic issue_slot();
        int next;
        next = (slots.size() > 0) ? slots.pop_front() : -1;
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = next;
        if (next >= 0) begin
            i_inst <= case_word(next, 1);
            i_pc <= case_word(next, 2);
            i_inst_valid <= 1'b1;
        end else begin
            i_inst <= '0;
            i_pc <= '0;
            i_inst_valid <= 1'b0;
        end
        // the load issued two edges ago is now in writeback
        i_mem_rdata <= (hist[2] >= 0) ? case_word(hist[2], 3) : '0;
    endtask

    // outputs are stable by the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_mem_req(o_mem_req, exp_mem_req(hist[1]));
            check_branch(o_branch, exp_branch(hist[1]));
            check_wb(o_wb, exp_wb(hist[2]));
            if (hist[2] >= 0)
                checked++;
        end
    end

    initial begin
        int gap;
        int extra;
        int cycles;
        i_reset = 1'b1;
        i_inst = '0;
        i_pc = '0;
        i_inst_valid = 1'b0;
        i_mem_rdata = '0;
        hist = '{-1, -1, -1};
        checking = 1'b0;
        checked = 0;
        num_cases = 0;
        seed = 52844;

        $readmemh("bench/rv32i_dx_cases.txt", case_words);
        while (num_cases < MAX_CASES && case_word(num_cases, 0) != 32'hffffffff)
            num_cases++;
        if (num_cases == 0 || num_cases == MAX_CASES) begin
            $display("cases file is missing, empty or has no end marker");
            stop_with_failure();
        end

        // random bubbles only where the file allows free spacing
        for (int k = 0; k < num_cases; k++) begin
            gap = case_word(k, 0);
            extra = (gap == 0) ? ($random(seed) & 1) : 0;
            repeat (gap + extra) slots.push_back(-1);
            slots.push_back(k);
        end

        repeat (3) @(posedge clk);
        i_reset <= 1'b0;
        checking = 1'b1;

        cycles = 0;
        while (checked < num_cases) begin
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: pipeline did not finish all cases in %0d cycles", cycles);
                stop_with_failure();
            end
            @(posedge clk);
            issue_slot();
            cycles++;
        end

        $display("Verification passed");
        $finish;
    end

endmodule : tb_rv32i_dx

// File: list.f
rtl/rv32i_types.sv
rtl/rv32i_packet.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/alu.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/rv32i_dx_core.sv
bench/clock_gen.sv
bench/tb_rv32i_dx.sv

// File: run.sh
#!/bin/sh
# Build the RV32I decode/execute testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_rv32i_dx -f list.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error" >> sim.log

cat sim.log
grep -q "Verification passed" sim.log \
    && echo "run ok" \
    || { echo "run FAILED"; exit 1; }

// File: bench/rv32i_dx_cases.txt
// gap inst pc rdata rw(2=read,1=write) addr wdata taken target wb_valid wb_rd wb_data
// gap: bubbles forced before the instruction, 0 lets the bench add a random one
0 00500093 00000100 00000000 0 0 0 0 0 1 01 00000005
0 ffd00113 00000104 00000000 0 0 0 0 0 1 02 fffffffd
0 00700013 00000108 00000000 0 0 0 0 0 1 00 00000007
0 123452b7 0000010c 00000000 0 0 0 0 0 1 05 12345000
0 00001317 00000110 00000000 0 0 0 0 0 1 06 00001110
0 402083b3 00000114 00000000 0 0 0 0 0 1 07 00000008
0 40115433 00000118 00000000 0 0 0 0 0 1 08 ffffffff
0 001154b3 0000011c 00000000 0 0 0 0 0 1 09 07ffffff
0 00112533 00000120 00000000 0 0 0 0 0 1 0a 00000001
0 001135b3 00000124 00000000 0 0 0 0 0 1 0b 00000000
0 0060a613 00000128 00000000 0 0 0 0 0 1 0c 00000001
0 40115693 0000012c 00000000 0 0 0 0 0 1 0d fffffffe
0 00000233 00000130 00000000 0 0 0 0 0 1 04 00000000
0 04000713 00000134 00000000 0 0 0 0 0 1 0e 00000040
2 00172223 00000138 00000000 1 44 5 0 0 0 00 00000000
0 00070783 0000013c 80f17f2e 2 40 0 0 0 1 0f 0000002e
0 00270803 00000140 80f17f2e 2 42 0 0 0 1 10 fffffff1
0 00374883 00000144 80f17f2e 2 43 0 0 0 1 11 00000080
0 00174903 00000148 80f17f2e 2 41 0 0 0 1 12 0000007f
0 00271983 0000014c 80f17f2e 2 42 0 0 0 1 13 ffff80f1
0 00075a03 00000150 80f17f2e 2 40 0 0 0 1 14 00007f2e
0 00275b03 00000154 80f17f2e 2 42 0 0 0 1 16 000080f1
0 00072a83 00000158 80f17f2e 2 40 0 0 0 1 15 80f17f2e
0 00108463 0000015c 00000000 0 0 0 1 00000164 0 00 00000000
0 00209463 00000160 00000000 0 0 0 1 00000168 0 00 00000000
0 00114463 00000164 00000000 0 0 0 1 0000016c 0 00 00000000
0 00115463 00000168 00000000 0 0 0 0 00000000 0 00 00000000
0 00116463 0000016c 00000000 0 0 0 0 00000000 0 00 00000000
0 00117463 00000170 00000000 0 0 0 1 00000178 0 00 00000000
0 01000bef 00000174 00000000 0 0 0 1 00000184 1 17 00000178
0 00408c67 00000178 00000000 0 0 0 1 00000008 1 18 0000017c
ffffffff 0 0 0 0 0 0 0 0 0 0 0
